// File: sim.f
tlk_tx_pkg.sv
tx_dma_fifo.sv
tx_frame_ctrl.sv
tx_word_gen.sv
tlk_tx_top.sv
tb_clock_gen.sv
tb_tlk_tx.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the tlk2711 transmit testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module tb_tlk_tx -f sim.f -o tb_tlk_tx
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

./obj_dir/tb_tlk_tx > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "Done: no errors" "$LOG"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

// File: tb_tlk_tx.sv
`timescale 1ns/1ps

module tb_tlk_tx;

    localparam int DMA_W        = 64;
    localparam int FIFO_DEPTH   = 16;
    localparam int SYNC_WORDS   = 6;
    localparam int GAP_WORDS    = 257;
    localparam int WAIT_LIMIT   = 20000;
    localparam int RUN_LIMIT    = 100000;

    logic             clk;
    logic             soft_reset;
    logic             dma_valid  = 1'b0;
    logic [DMA_W-1:0] dma_data   = '0;
    logic             dma_ready;
    logic             tx_start   = 1'b0;
    logic [15:0]      body_len   = '0;
    logic [15:0]      tail_len   = '0;
    logic [15:0]      last_frame = '0;
    logic [15:0]      intr_width = '0;
    logic             tx_interrupt;
    logic [15:0]      txd;
    logic             tkmsb;
    logic             tklsb;
    logic             tx_enable;
    logic             lckrefn;

    // words on the link as {tkmsb, tklsb, txd}
    logic [17:0]      exp_q[$];
    logic [17:0]      got_q[$];
    logic [15:0]      pay_q[$];
    logic [DMA_W-1:0] feed_q[$];
    int               sof_runs[$];
    int               intr_widths[$];

    // separate streams, same seed
    logic [15:0] data_lfsr  = 16'd53;
    logic [15:0] valid_lfsr = 16'd53;

    int          feed_idx   = 0;
    int          drop_count = 0;
    int          idle_run   = 0;
    int          intr_len   = 0;
    logic        armed      = 1'b0;
    int          cmp_idx    = 0;
    logic [17:0] cmp_got;
    int          cmp_errors = 0;
    int          mon_errors = 0;
    int          tst_errors = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;
    logic        abort_req  = 1'b0;
    string       abort_msg  = "";

    tb_clock_gen u_clk (
        .o_clk        (clk),
        .o_soft_reset (soft_reset)
    );

    tlk_tx_top #(
        .DMA_W      (DMA_W),
        .FIFO_DEPTH (FIFO_DEPTH),
        .SYNC_WORDS (SYNC_WORDS),
        .GAP_WORDS  (GAP_WORDS)
    ) dut (
        .clk            (clk),
        .i_soft_reset   (soft_reset),
        .i_dma_valid    (dma_valid),
        .i_dma_data     (dma_data),
        .o_dma_ready    (dma_ready),
        .i_tx_start     (tx_start),
        .i_body_len     (body_len),
        .i_tail_len     (tail_len),
        .i_last_frame   (last_frame),
        .i_intr_width   (intr_width),
        .o_tx_interrupt (tx_interrupt),
        .o_2711_txd     (txd),
        .o_2711_tkmsb   (tkmsb),
        .o_2711_tklsb   (tklsb),
        .o_2711_enable  (tx_enable),
        .o_2711_lckrefn (lckrefn)
    );

    ////////////////////
    // reference model
    ////////////////////

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    function automatic void build_frame(input logic [15:0] num, input logic [15:0] len,
                                        input logic is_last);
        logic [15:0] sum;
        logic [15:0] word;
        int          i;
        sum = num + len;
        exp_q.push_back({2'b11, tlk_tx_pkg::SOF_WORD});
        exp_q.push_back({2'b00, tlk_tx_pkg::HEAD_0});
        exp_q.push_back({2'b00, tlk_tx_pkg::HEAD_1});
        exp_q.push_back({2'b00, tlk_tx_pkg::TX_IND, is_last ? tlk_tx_pkg::FILE_END : 8'h00});
        exp_q.push_back({2'b00, num});
        exp_q.push_back({2'b00, len});
        for (i = 0; i < int'(len) / 2; i++) begin
            word = pay_q.pop_front();
            sum  = sum + word;
            exp_q.push_back({2'b00, word});
        end
        exp_q.push_back({2'b00, sum});
        exp_q.push_back({2'b11, tlk_tx_pkg::EOF_WORD});
    endfunction

    function automatic int error_total();
        return cmp_errors + mon_errors + tst_errors;
    endfunction

    ////////////////////
    // dma source
    ////////////////////

    always @(posedge clk) begin
        if (soft_reset) begin
            dma_valid <= 1'b0;
        end else if (dma_valid && !dma_ready) begin
            // offer held while the buffer is full
            drop_count++;
        end else begin
            if (dma_valid) begin
                feed_idx++;
            end
            valid_lfsr = lfsr_next(valid_lfsr);
            if (feed_idx < feed_q.size() && valid_lfsr[0]) begin
                dma_valid <= 1'b1;
                dma_data  <= feed_q[feed_idx];
            end else begin
                dma_valid <= 1'b0;
            end
        end
    end

    ////////////////////
    // link monitor
    ////////////////////

    always @(posedge clk) begin
        if (soft_reset) begin
            idle_run = 0;
        end else begin
            if (txd == tlk_tx_pkg::IDLE_WORD && tklsb && !tkmsb) begin
                idle_run++;
            end else begin
                if (txd == tlk_tx_pkg::SOF_WORD && tkmsb && tklsb) begin
                    sof_runs.push_back(idle_run);
                end
                got_q.push_back({tkmsb, tklsb, txd});
                idle_run = 0;
            end
            // count sync words from the accepted strobe
            if (tx_start && !armed) begin
                armed    = 1'b1;
                idle_run = 0;
            end
            if (tx_interrupt) begin
                if (intr_len == 0) begin
                    assert (armed && idle_run == GAP_WORDS && got_q.size() == exp_q.size())
                    else begin
                        $display("[ERROR] %0t: interrupt after %0d idle words, %0d/%0d words",
                                 $time, idle_run, got_q.size(), exp_q.size());
                        mon_errors++;
                    end
                end
                intr_len++;
            end else if (intr_len != 0) begin
                intr_widths.push_back(intr_len);
                intr_len = 0;
                armed    = 1'b0;
            end
        end
    end

    always @(negedge clk) begin
        while (cmp_idx < got_q.size()) begin
            cmp_got = got_q[cmp_idx];
            assert (cmp_idx < exp_q.size()) else begin
                $display("[ERROR] %0t: extra word %h on the link", $time, cmp_got);
                cmp_errors++;
            end
            if (cmp_idx < exp_q.size()) begin
                assert (cmp_got == exp_q[cmp_idx]) else begin
                    $display("[ERROR] %0t: word %0d is %h, expected %h",
                             $time, cmp_idx, cmp_got, exp_q[cmp_idx]);
                    cmp_errors++;
                end
            end
            cmp_idx++;
        end
    end

    ////////////////////
    // test tasks
    ////////////////////

    task automatic abort_run(input string what);
        abort_msg = what;
        abort_req = 1'b1;
        // parked until the run limiter ends the simulation
        forever @(posedge clk);
    endtask

    task automatic value_error(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        tst_errors++;
    endtask

    task automatic run_transfer(input logic [15:0] body, input logic [15:0] tail,
                                input logic [15:0] last_idx, input logic [15:0] width,
                                input bit extra_strobe);
        int               total;
        int               n;
        int               i;
        int               sof_first;
        int               pulses;
        int               got_base;
        logic [DMA_W-1:0] w;
        total = int'(body) * int'(last_idx) + int'(tail);
        @(negedge clk);
        for (n = 0; n < total / 8; n++) begin
            w = '0;
            for (i = 0; i < DMA_W; i++) begin
                data_lfsr = lfsr_next(data_lfsr);
                w = {w[DMA_W-2:0], data_lfsr[0]};
            end
            feed_q.push_back(w);
            for (i = 0; i < DMA_W / 16; i++) begin
                pay_q.push_back(w[i*16 +: 16]);
            end
        end
        for (n = 0; n <= int'(last_idx); n++) begin
            build_frame(16'(n), (n == int'(last_idx)) ? tail : body, n == int'(last_idx));
        end
        sof_first = sof_runs.size();
        pulses    = intr_widths.size();
        got_base  = got_q.size();
        @(posedge clk);
        tx_start   <= 1'b1;
        body_len   <= body;
        tail_len   <= tail;
        last_frame <= last_idx;
        intr_width <= width;
        @(posedge clk);
        tx_start <= 1'b0;
        if (extra_strobe) begin
            n = 0;
            while (got_q.size() < got_base + 4 && n < WAIT_LIMIT) begin
                @(negedge clk);
                n++;
            end
            if (got_q.size() < got_base + 4) begin
                abort_run("the first frame words");
            end
            @(posedge clk);
            tx_start   <= 1'b1;
            body_len   <= body + 16'd8;
            last_frame <= last_idx + 16'd4;
            @(posedge clk);
            tx_start <= 1'b0;
        end
        n = 0;
        while (intr_widths.size() == pulses && n < WAIT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        if (intr_widths.size() == pulses) begin
            abort_run("the transfer interrupt");
        end
        @(posedge clk);
        assert (intr_widths.size() == pulses + 1 && intr_widths[pulses] == int'(width)) else
            value_error($sformatf("interrupt width %0d, expected %0d",
                                  intr_widths[pulses], width));
        assert (cmp_idx == exp_q.size()) else
            value_error($sformatf("%0d words checked, %0d expected", cmp_idx, exp_q.size()));
        assert (sof_runs.size() - sof_first == int'(last_idx) + 1) else
            value_error($sformatf("%0d frames seen", sof_runs.size() - sof_first));
        for (n = sof_first; n < sof_runs.size(); n++) begin
            if (n == sof_first) begin
                assert (sof_runs[n] >= SYNC_WORDS) else
                    value_error($sformatf("only %0d sync words before the first frame",
                                          sof_runs[n]));
            end else begin
                assert (sof_runs[n] == GAP_WORDS) else
                    value_error($sformatf("%0d idle words before frame %0d, expected %0d",
                                          sof_runs[n], n - sof_first, GAP_WORDS));
            end
        end
    endtask

    task automatic report_test(input int num, input string name, input int base);
        int errs;
        errs = error_total() - base;
        tests_run++;
        if (errs == 0) begin
            $display("test %0d %s: pass", num, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: FAIL with %0d errors", num, name, errs);
        end
    endtask

    ////////////////////
    // test sequence
    ////////////////////

    initial begin : main
        int base;
        int n;
        int drops;
        base = 0;
        @(negedge clk);
        assert (!tx_enable && !lckrefn && txd == tlk_tx_pkg::IDLE_WORD && !tx_interrupt) else
            value_error("pins not in reset state during reset");
        n = 0;
        while (soft_reset && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (soft_reset) begin
            abort_run("reset release");
        end
        @(posedge clk);
        @(negedge clk);
        assert (!tx_interrupt && dma_ready && tx_enable && lckrefn) else
            value_error("control outputs wrong after reset");
        assert (txd == tlk_tx_pkg::IDLE_WORD && tklsb && !tkmsb) else
            value_error($sformatf("pins %h/%b%b after reset", txd, tkmsb, tklsb));
        report_test(1, "reset state", base);

        base = error_total();
        run_transfer(16'd32, 16'd16, 16'd0, 16'd3, 1'b0);
        report_test(2, "single frame", base);

        base = error_total();
        run_transfer(16'd40, 16'd24, 16'd2, 16'd2, 1'b0);
        report_test(3, "three frames", base);

        // frame lengths that split dma entries across frames
        base = error_total();
        run_transfer(16'd12, 16'd4, 16'd3, 16'd1, 1'b0);
        report_test(4, "frame gaps", base);

        base = error_total();
        run_transfer(16'd24, 16'd8, 16'd1, 16'd7, 1'b1);
        run_transfer(16'd8, 16'd16, 16'd2, 16'd2, 1'b0);
        report_test(5, "interrupt and restart", base);

        base  = error_total();
        drops = drop_count;
        run_transfer(16'd128, 16'd128, 16'd3, 16'd4, 1'b0);
        assert (drop_count > drops) else
            value_error("o_dma_ready never dropped with a full buffer");
        report_test(6, "buffer back-pressure", base);

        $display("tests %0d, failed %0d, words checked %0d, error count %0d",
                 tests_run, tests_failed, cmp_idx, error_total());
        if (error_total() == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin : run_limit
        int cycles;
        cycles = 0;
        while (!abort_req && cycles < RUN_LIMIT) begin
            @(posedge clk);
            cycles++;
        end
        if (abort_req) begin
            $display("timeout: %s did not arrive in time", abort_msg);
        end else begin
            $display("run limit of %0d cycles reached", RUN_LIMIT);
        end
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 5,
    parameter int RESET_CYCLES = 5
) (
    output logic o_clk,
    output logic o_soft_reset
);

    initial begin
        o_clk = 1'b0;
        forever #(HALF_PERIOD) o_clk = ~o_clk;
    end

    // reset released on a rising edge
    initial begin
        o_soft_reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge o_clk);
        o_soft_reset <= 1'b0;
    end

endmodule

// File: tlk_tx_top.sv
`timescale 1ns/1ps

module tlk_tx_top #(
    parameter int DMA_W      = 64,
    parameter int FIFO_DEPTH = 128,
    parameter int SYNC_WORDS = 6,
    parameter int GAP_WORDS  = 257
) (
    input  logic                          clk,
    input  logic                          i_soft_reset,
    // dma source
    input  logic                          i_dma_valid,
    input  logic [DMA_W-1:0]              i_dma_data,
    output logic                          o_dma_ready,
    // control
    input  logic                          i_tx_start,
    input  logic [15:0]                   i_body_len,
    input  logic [15:0]                   i_tail_len,
    input  logic [15:0]                   i_last_frame,
    input  logic [15:0]                   i_intr_width,
    output logic                          o_tx_interrupt,
    // tlk2711 pins
    output logic [tlk_tx_pkg::WORD_W-1:0] o_2711_txd,
    output logic                          o_2711_tkmsb,
    output logic                          o_2711_tklsb,
    output logic                          o_2711_enable,
    output logic                          o_2711_lckrefn
);

    // buffer capacity in link words
    localparam int LEVEL_W = $clog2(FIFO_DEPTH * (DMA_W / tlk_tx_pkg::WORD_W) + 1);

    logic                          rd_en;
    logic [tlk_tx_pkg::WORD_W-1:0] rd_data;
    logic [LEVEL_W-1:0]            level;
    tlk_tx_pkg::tx_field_t         field;
    logic [tlk_tx_pkg::WORD_W-1:0] frame_num;
    logic [tlk_tx_pkg::WORD_W-1:0] frame_len;
    logic                          last;

    tx_dma_fifo #(
        .DMA_W      (DMA_W),
        .FIFO_DEPTH (FIFO_DEPTH),
        .LEVEL_W    (LEVEL_W)
    ) u_fifo (
        .clk          (clk),
        .i_soft_reset (i_soft_reset),
        .i_dma_valid  (i_dma_valid),
        .i_dma_data   (i_dma_data),
        .o_dma_ready  (o_dma_ready),
        .i_rd_en      (rd_en),
        .o_rd_data    (rd_data),
        .o_level      (level)
    );

    tx_frame_ctrl #(
        .LEVEL_W    (LEVEL_W),
        .SYNC_WORDS (SYNC_WORDS),
        .GAP_WORDS  (GAP_WORDS)
    ) u_ctrl (
        .clk            (clk),
        .i_soft_reset   (i_soft_reset),
        .i_tx_start     (i_tx_start),
        .i_body_len     (i_body_len),
        .i_tail_len     (i_tail_len),
        .i_last_frame   (i_last_frame),
        .i_intr_width   (i_intr_width),
        .i_level        (level),
        .o_rd_en        (rd_en),
        .o_field        (field),
        .o_frame_num    (frame_num),
        .o_frame_len    (frame_len),
        .o_last         (last),
        .o_tx_interrupt (o_tx_interrupt)
    );

    tx_word_gen u_word_gen (
        .clk            (clk),
        .i_soft_reset   (i_soft_reset),
        .i_field        (field),
        .i_frame_num    (frame_num),
        .i_frame_len    (frame_len),
        .i_last         (last),
        .i_rd_data      (rd_data),
        .o_2711_txd     (o_2711_txd),
        .o_2711_tkmsb   (o_2711_tkmsb),
        .o_2711_tklsb   (o_2711_tklsb),
        .o_2711_enable  (o_2711_enable),
        .o_2711_lckrefn (o_2711_lckrefn)
    );

endmodule

// File: tx_word_gen.sv
`timescale 1ns/1ps

module tx_word_gen (
    input  logic                          clk,
    input  logic                          i_soft_reset,
    input  tlk_tx_pkg::tx_field_t         i_field,
    input  logic [tlk_tx_pkg::WORD_W-1:0] i_frame_num,
    input  logic [tlk_tx_pkg::WORD_W-1:0] i_frame_len,
    input  logic                          i_last,
    input  logic [tlk_tx_pkg::WORD_W-1:0] i_rd_data,
    output logic [tlk_tx_pkg::WORD_W-1:0] o_2711_txd,
    output logic                          o_2711_tkmsb,
    output logic                          o_2711_tklsb,
    output logic                          o_2711_enable,
    output logic                          o_2711_lckrefn
);

    logic [tlk_tx_pkg::WORD_W-1:0] next_txd;
    logic                          next_tkmsb;
    logic                          next_tklsb;
    logic [tlk_tx_pkg::WORD_W-1:0] checksum;
    logic                          eof_due;

    ////////////////////
    // word select
    ////////////////////

    always_comb begin
        next_txd   = tlk_tx_pkg::IDLE_WORD;
        next_tkmsb = 1'b0;
        next_tklsb = 1'b1;
        if (eof_due) begin
            next_txd   = tlk_tx_pkg::EOF_WORD;
            next_tkmsb = 1'b1;
        end else begin
            case (i_field)
                tlk_tx_pkg::FLD_SOF: begin
                    next_txd   = tlk_tx_pkg::SOF_WORD;
                    next_tkmsb = 1'b1;
                end
                tlk_tx_pkg::FLD_HEAD0: begin
                    next_txd   = tlk_tx_pkg::HEAD_0;
                    next_tklsb = 1'b0;
                end
                tlk_tx_pkg::FLD_HEAD1: begin
                    next_txd   = tlk_tx_pkg::HEAD_1;
                    next_tklsb = 1'b0;
                end
                tlk_tx_pkg::FLD_FILE_SIGN: begin
                    next_txd   = {tlk_tx_pkg::TX_IND, i_last ? tlk_tx_pkg::FILE_END : 8'h00};
                    next_tklsb = 1'b0;
                end
                tlk_tx_pkg::FLD_FRAME_NUM: begin
                    next_txd   = i_frame_num;
                    next_tklsb = 1'b0;
                end
                tlk_tx_pkg::FLD_LENGTH: begin
                    next_txd   = i_frame_len;
                    next_tklsb = 1'b0;
                end
                tlk_tx_pkg::FLD_DATA: begin
                    next_txd   = i_rd_data;
                    next_tklsb = 1'b0;
                end
                tlk_tx_pkg::FLD_CHECKSUM: begin
                    next_txd   = checksum;
                    next_tklsb = 1'b0;
                end
                default: ;
            endcase
        end
    end

    ////////////////////
    // checksum and pins
    ////////////////////

    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            checksum       <= '0;
            eof_due        <= 1'b0;
            o_2711_txd     <= tlk_tx_pkg::IDLE_WORD;
            o_2711_tkmsb   <= 1'b0;
            o_2711_tklsb   <= 1'b1;
            o_2711_enable  <= 1'b0;
            o_2711_lckrefn <= 1'b0;
        end else begin
            // sum of frame number, length and payload
            if (i_field == tlk_tx_pkg::FLD_SOF) begin
                checksum <= '0;
            end else if (i_field == tlk_tx_pkg::FLD_FRAME_NUM ||
                         i_field == tlk_tx_pkg::FLD_LENGTH ||
                         i_field == tlk_tx_pkg::FLD_DATA) begin
                checksum <= checksum + next_txd;
            end
            eof_due        <= (i_field == tlk_tx_pkg::FLD_CHECKSUM);
            o_2711_txd     <= next_txd;
            o_2711_tkmsb   <= next_tkmsb;
            o_2711_tklsb   <= next_tklsb;
            o_2711_enable  <= 1'b1;
            o_2711_lckrefn <= 1'b1;
        end
    end

endmodule

// File: tx_frame_ctrl.sv
`timescale 1ns/1ps

module tx_frame_ctrl #(
    parameter int LEVEL_W    = 10,
    parameter int SYNC_WORDS = 6,
    parameter int GAP_WORDS  = 257
) (
    input  logic                          clk,
    input  logic                          i_soft_reset,
    input  logic                          i_tx_start,
    input  logic [15:0]                   i_body_len,
    input  logic [15:0]                   i_tail_len,
    input  logic [15:0]                   i_last_frame,
    input  logic [15:0]                   i_intr_width,
    input  logic [LEVEL_W-1:0]            i_level,
    output logic                          o_rd_en,
    output tlk_tx_pkg::tx_field_t         o_field,
    output logic [tlk_tx_pkg::WORD_W-1:0] o_frame_num,
    output logic [tlk_tx_pkg::WORD_W-1:0] o_frame_len,
    output logic                          o_last,
    output logic                          o_tx_interrupt
);

    localparam int SYNC_CW = $clog2(SYNC_WORDS + 1);
    localparam int GAP_CW  = $clog2(GAP_WORDS + 1);

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_SYNC,
        ST_WAIT,
        ST_SOF,
        ST_HEAD0,
        ST_HEAD1,
        ST_FSIGN,
        ST_FNUM,
        ST_LEN,
        ST_DATA,
        ST_CSUM,
        ST_EOF,
        ST_GAP,
        ST_INTR
    } state_t;

    state_t state;

    // configuration, latched on the start strobe
    logic [15:0] body_len;
    logic [15:0] tail_len;
    logic [15:0] last_frame;
    logic [15:0] intr_width;

    logic [15:0]        frame_num;
    logic [SYNC_CW-1:0] sync_cnt;
    logic [14:0]        data_cnt;
    logic [GAP_CW-1:0]  gap_cnt;
    logic [15:0]        intr_cnt;
    // set at the end-of-frame once the last frame has gone out
    logic               last_sent;

    logic        last;
    logic [15:0] frame_len;
    logic [14:0] data_words;
    logic [15:0] level_ext;
    logic        level_ok;

    assign last       = (frame_num == last_frame);
    assign frame_len  = last ? tail_len : body_len;
    assign data_words = frame_len[15:1];
    assign level_ext  = 16'(i_level);
    assign level_ok   = (level_ext >= {1'b0, data_words});

    always_ff @(posedge clk) begin
        if (state == ST_IDLE && i_tx_start) begin
            body_len   <= i_body_len;
            tail_len   <= i_tail_len;
            last_frame <= i_last_frame;
            intr_width <= i_intr_width;
        end
    end

    ////////////////////
    // frame sequencing
    ////////////////////

    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            state     <= ST_IDLE;
            frame_num <= '0;
            sync_cnt  <= '0;
            data_cnt  <= '0;
            gap_cnt   <= '0;
            intr_cnt  <= '0;
            last_sent <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (i_tx_start) begin
                        frame_num <= '0;
                        sync_cnt  <= '0;
                        state     <= ST_SYNC;
                    end
                end
                ST_SYNC: begin
                    sync_cnt <= sync_cnt + 1'b1;
                    if (sync_cnt == SYNC_CW'(SYNC_WORDS - 1)) begin
                        state <= ST_WAIT;
                    end
                end
                // hold idle until the whole payload is buffered
                ST_WAIT: begin
                    if (level_ok) begin
                        state <= ST_SOF;
                    end
                end
                ST_SOF:   state <= ST_HEAD0;
                ST_HEAD0: state <= ST_HEAD1;
                ST_HEAD1: state <= ST_FSIGN;
                ST_FSIGN: state <= ST_FNUM;
                ST_FNUM:  state <= ST_LEN;
                ST_LEN: begin
                    data_cnt <= '0;
                    state    <= (data_words == '0) ? ST_CSUM : ST_DATA;
                end
                ST_DATA: begin
                    data_cnt <= data_cnt + 1'b1;
                    if (data_cnt == data_words - 1'b1) begin
                        state <= ST_CSUM;
                    end
                end
                ST_CSUM:  state <= ST_EOF;
                ST_EOF: begin
                    gap_cnt   <= '0;
                    last_sent <= last;
                    if (!last) begin
                        frame_num <= frame_num + 1'b1;
                    end
                    state <= ST_GAP;
                end
                ST_GAP: begin
                    gap_cnt <= gap_cnt + 1'b1;
                    if (gap_cnt == GAP_CW'(GAP_WORDS - 1)) begin
                        intr_cnt <= '0;
                        if (last_sent) begin
                            state <= ST_INTR;
                        end else if (level_ok) begin
                            // next frame starts straight after the gap
                            state <= ST_SOF;
                        end else begin
                            state <= ST_WAIT;
                        end
                    end
                end
                ST_INTR: begin
                    intr_cnt <= intr_cnt + 1'b1;
                    // a zero width still gives one cycle
                    if (intr_cnt + 16'd1 >= intr_width) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    ////////////////////
    // field codes
    ////////////////////

    always_comb begin
        case (state)
            ST_SOF:   o_field = tlk_tx_pkg::FLD_SOF;
            ST_HEAD0: o_field = tlk_tx_pkg::FLD_HEAD0;
            ST_HEAD1: o_field = tlk_tx_pkg::FLD_HEAD1;
            ST_FSIGN: o_field = tlk_tx_pkg::FLD_FILE_SIGN;
            ST_FNUM:  o_field = tlk_tx_pkg::FLD_FRAME_NUM;
            ST_LEN:   o_field = tlk_tx_pkg::FLD_LENGTH;
            ST_DATA:  o_field = tlk_tx_pkg::FLD_DATA;
            ST_CSUM:  o_field = tlk_tx_pkg::FLD_CHECKSUM;
            default:  o_field = tlk_tx_pkg::FLD_IDLE;
        endcase
    end

    assign o_rd_en        = (state == ST_DATA);
    assign o_frame_num    = frame_num;
    assign o_frame_len    = frame_len;
    assign o_last         = last;
    // rises with the last gap word on the pins
    assign o_tx_interrupt = (state == ST_INTR);

endmodule

// File: tx_dma_fifo.sv
`timescale 1ns/1ps

module tx_dma_fifo #(
    parameter int DMA_W      = 64,
    parameter int FIFO_DEPTH = 128,
    parameter int LEVEL_W    = 10
) (
    input  logic                          clk,
    input  logic                          i_soft_reset,
    input  logic                          i_dma_valid,
    input  logic [DMA_W-1:0]              i_dma_data,
    output logic                          o_dma_ready,
    input  logic                          i_rd_en,
    output logic [tlk_tx_pkg::WORD_W-1:0] o_rd_data,
    output logic [LEVEL_W-1:0]            o_level
);

    localparam int LANES = DMA_W / tlk_tx_pkg::WORD_W;
    localparam int AW    = $clog2(FIFO_DEPTH);
    localparam int CW    = $clog2(FIFO_DEPTH + 1);
    localparam int LW    = $clog2(LANES);

    logic [DMA_W-1:0] mem [FIFO_DEPTH];

    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;
    logic [LW-1:0] lane;

    logic full;
    logic push;
    logic pop_word;
    logic pop_entry;

    assign full        = (count == CW'(FIFO_DEPTH));
    assign o_dma_ready = ~full;
    assign push        = i_dma_valid & o_dma_ready;

    // a read on an empty buffer is dropped
    assign pop_word  = i_rd_en & (count != '0);
    assign pop_entry = pop_word & (lane == LW'(LANES - 1));

    ////////////////////
    // storage
    ////////////////////

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= i_dma_data;
        end
    end

    // low half first
    assign o_rd_data = mem[rd_ptr][lane*tlk_tx_pkg::WORD_W +: tlk_tx_pkg::WORD_W];

    ////////////////////
    // pointers and count
    ////////////////////

    always_ff @(posedge clk) begin
        if (i_soft_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            lane   <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_entry) begin
                rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (pop_word) begin
                lane <= pop_entry ? '0 : lane + 1'b1;
            end
            count <= count + CW'(push) - CW'(pop_entry);
        end
    end

    // fill level in link words, minus lanes already read
    assign o_level = LEVEL_W'(count * LANES) - LEVEL_W'(lane);

endmodule

// File: tlk_tx_pkg.sv
package tlk_tx_pkg;

    ////////////////////
    // link word
    ////////////////////

    localparam int WORD_W = 16;

    // comma, D5.6 over K28.5, low K flag only
    localparam logic [WORD_W-1:0] IDLE_WORD = 16'hC5BC;

    // K28.2 over K27.7, both K flags
    localparam logic [WORD_W-1:0] SOF_WORD = 16'h5CFB;

    // K29.7 over K30.7, both K flags
    localparam logic [WORD_W-1:0] EOF_WORD = 16'hFDFE;

    ////////////////////
    // frame header
    ////////////////////

    localparam logic [WORD_W-1:0] HEAD_0 = 16'hEB90;
    localparam logic [WORD_W-1:0] HEAD_1 = 16'hE116;

    // data type, high byte of the file-sign word
    localparam logic [7:0] TX_IND = 8'h81;

    // low byte of the file-sign word on the last frame
    localparam logic [7:0] FILE_END = 8'h01;

    ////////////////////
    // frame fields
    ////////////////////

    // the end-of-frame word always follows the checksum,
    // so the word builder inserts it by itself
    typedef enum logic [3:0] {
        FLD_IDLE,
        FLD_SOF,
        FLD_HEAD0,
        FLD_HEAD1,
        FLD_FILE_SIGN,
        FLD_FRAME_NUM,
        FLD_LENGTH,
        FLD_DATA,
        FLD_CHECKSUM
    } tx_field_t;

endpackage
